//--- build.f
design/sim_bus_pkg.sv
design/latency_config.sv
design/read_responder.sv
design/write_responder.sv
design/uart_capture.sv
design/sim_bus_top.sv
verification/sim_bus_assertions.sv
verification/sim_bus_tb.sv

//--- design/latency_config.sv
`timescale 1ns/1ps
`default_nettype none

module latency_config (
    input  logic                      clk,
    input  logic                      rst,
    input  sim_bus_pkg::write_event_t write_evt,
    output sim_bus_pkg::latency_cfg_t latency
);
    import sim_bus_pkg::*;

    logic cfg_hit;

    // a completed write landing on the latency register
    assign cfg_hit = write_evt.valid && (write_evt.offset == latency_offset);

    ////////////////////
    // delay registers

    always_ff @(posedge clk) begin
        if (rst) begin
            latency.read_lat  <= default_latency;
            latency.write_lat <= default_latency;
        end else if (cfg_hit) begin
            // both channels reprogrammed from the same word
            latency.read_lat  <= write_evt.data.latency_view.read_lat;
            latency.write_lat <= write_evt.data.latency_view.write_lat;
        end
    end

endmodule

`default_nettype wire

//--- design/read_responder.sv
`timescale 1ns/1ps
`default_nettype none

module read_responder (
    input  logic                             clk,
    input  logic                             rst,
    input  sim_bus_pkg::latency_cfg_t        latency,
    input  logic                             ar_valid,
    input  logic [sim_bus_pkg::addr_w-1:0]   ar_addr,
    output logic                             ar_ready,
    output logic                             r_valid,
    output logic [sim_bus_pkg::data_w-1:0]   r_data,
    input  logic                             r_ready
);
    import sim_bus_pkg::*;

    logic [1:0]       state;
    logic [lat_w-1:0] count;
    logic             ar_fire;
    logic             r_fire;

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;

    ////////////////////
    // idle, counting, responding

    // ar_addr is not decoded, every read returns the fill word
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (ar_fire) begin
                        state <= st_count;
                        count <= latency.read_lat;
                    end
                end
                st_count: begin
                    // zero count still costs one edge
                    if (count == '0) begin
                        state <= st_resp;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                st_resp: begin
                    if (r_fire) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    ////////////////////
    // channel outputs

    // address is only taken again once the data beat is gone
    assign ar_ready = (state == st_idle);
    assign r_valid  = (state == st_resp);
    assign r_data   = read_fill_data;

endmodule

`default_nettype wire

//--- design/sim_bus_pkg.sv
`default_nettype none

package sim_bus_pkg;

    ////////////////////
    // bus widths

    localparam int addr_w   = 32;
    localparam int data_w   = 32;
    localparam int strb_w   = data_w / 8;
    localparam int lat_w    = 4;
    localparam int offset_w = 14;

    ////////////////////
    // address map and reset values

    // low address bits compared against these
    localparam logic [offset_w-1:0] uart_offset    = 14'd4096;
    localparam logic [offset_w-1:0] latency_offset = 14'd4100;

    localparam logic [lat_w-1:0]  default_latency = 4'd5;
    localparam logic [data_w-1:0] read_fill_data  = 32'hFFFF_FF21;

    // responder sequence, the read side skips st_data
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_count = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_resp  = 2'd3;

    ////////////////////
    // channel and event types

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } bus_write_t;

    // one write word, seen as a uart byte or as the latency register
    typedef union packed {
        struct packed {
            logic [data_w-9:0] unused;
            logic [7:0]        tx_byte;
        } uart_view;
        struct packed {
            logic [data_w-2*lat_w-1:0] unused;
            logic [lat_w-1:0]          write_lat;
            logic [lat_w-1:0]          read_lat;
        } latency_view;
    } write_data_u;

    typedef struct packed {
        logic                valid;
        logic [offset_w-1:0] offset;
        write_data_u         data;
    } write_event_t;

    typedef struct packed {
        logic [lat_w-1:0] read_lat;
        logic [lat_w-1:0] write_lat;
    } latency_cfg_t;

endpackage

`default_nettype wire

//--- design/sim_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module sim_bus_top (
    input  logic                             clk,
    input  logic                             rst,

    // read channel
    input  logic                             ar_valid,
    input  logic [sim_bus_pkg::addr_w-1:0]   ar_addr,
    output logic                             ar_ready,
    output logic                             r_valid,
    output logic [sim_bus_pkg::data_w-1:0]   r_data,
    input  logic                             r_ready,

    // write channel
    input  logic                             aw_valid,
    input  logic [sim_bus_pkg::addr_w-1:0]   aw_addr,
    output logic                             aw_ready,
    input  logic                             w_valid,
    input  sim_bus_pkg::bus_write_t          w_beat,
    output logic                             w_ready,
    output logic                             b_valid,
    input  logic                             b_ready,

    // captured uart bytes
    output logic                             uart_valid,
    output logic [7:0]                       uart_byte
);
    import sim_bus_pkg::*;

    latency_cfg_t latency;
    write_event_t write_evt;

    latency_config latency_config_inst (
        .clk       (clk),
        .rst       (rst),
        .write_evt (write_evt),
        .latency   (latency)
    );

    read_responder read_responder_inst (
        .clk      (clk),
        .rst      (rst),
        .latency  (latency),
        .ar_valid (ar_valid),
        .ar_addr  (ar_addr),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_data   (r_data),
        .r_ready  (r_ready)
    );

    write_responder write_responder_inst (
        .clk       (clk),
        .rst       (rst),
        .latency   (latency),
        .aw_valid  (aw_valid),
        .aw_addr   (aw_addr),
        .aw_ready  (aw_ready),
        .w_valid   (w_valid),
        .w_beat    (w_beat),
        .w_ready   (w_ready),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .write_evt (write_evt)
    );

    uart_capture uart_capture_inst (
        .clk        (clk),
        .rst        (rst),
        .write_evt  (write_evt),
        .uart_valid (uart_valid),
        .uart_byte  (uart_byte)
    );

endmodule

`default_nettype wire

//--- design/uart_capture.sv
`timescale 1ns/1ps
`default_nettype none

module uart_capture (
    input  logic                      clk,
    input  logic                      rst,
    input  sim_bus_pkg::write_event_t write_evt,
    output logic                      uart_valid,
    output logic [7:0]                uart_byte
);
    import sim_bus_pkg::*;

    logic uart_hit;

    assign uart_hit = write_evt.valid && (write_evt.offset == uart_offset);

    // one strobe per event, byte holds until the next uart write
    always_ff @(posedge clk) begin
        if (uart_hit) begin
            uart_byte <= write_evt.data.uart_view.tx_byte;
        end

        if (rst) begin
            uart_valid <= 1'b0;
        end else begin
            uart_valid <= uart_hit;
        end
    end

endmodule

`default_nettype wire

//--- design/write_responder.sv
`timescale 1ns/1ps
`default_nettype none

module write_responder (
    input  logic                             clk,
    input  logic                             rst,
    input  sim_bus_pkg::latency_cfg_t        latency,
    input  logic                             aw_valid,
    input  logic [sim_bus_pkg::addr_w-1:0]   aw_addr,
    output logic                             aw_ready,
    input  logic                             w_valid,
    input  sim_bus_pkg::bus_write_t          w_beat,
    output logic                             w_ready,
    output logic                             b_valid,
    input  logic                             b_ready,
    output sim_bus_pkg::write_event_t        write_evt
);
    import sim_bus_pkg::*;

    logic [1:0]          state;
    logic [lat_w-1:0]    count;
    logic [offset_w-1:0] offset_q;
    logic                aw_fire;
    logic                w_fire;
    logic                b_fire;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;

    ////////////////////
    // idle, counting, data ready, responding

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            offset_q <= aw_addr[offset_w-1:0];
        end

        if (rst) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (aw_fire) begin
                        state <= st_count;
                        count <= latency.write_lat;
                    end
                end
                st_count: begin
                    if (count == '0) begin
                        state <= st_data;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                st_data: begin
                    if (w_fire) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    // aw_ready comes back on this edge
                    if (b_fire) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    ////////////////////
    // write event

    // one-cycle event after each accepted w beat
    always_ff @(posedge clk) begin
        if (w_fire) begin
            write_evt.offset <= offset_q;
            write_evt.data   <= w_beat.data;
        end

        if (rst) begin
            write_evt.valid <= 1'b0;
        end else begin
            write_evt.valid <= w_fire;
        end
    end

    assign aw_ready = (state == st_idle);
    assign w_ready  = (state == st_data);
    assign b_valid  = (state == st_resp);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sim_bus_tb -Mdir obj_dir -o sim_bus_sim -f build.f > build.log 2>&1 &&
    ./obj_dir/sim_bus_sim > sim.log 2>&1 &&
    ! grep -q "tests failed" sim.log &&
    echo "PASS" ||
    { echo "FAIL, see build.log and sim.log"; exit 1; }

//--- verification/sim_bus_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module sim_bus_assertions (
    input logic                           clk,
    input logic                           rst,
    input logic                           ar_ready,
    input logic                           r_valid,
    input logic [sim_bus_pkg::data_w-1:0] r_data,
    input logic                           r_ready,
    input logic                           b_valid,
    input logic                           b_ready,
    input logic                           uart_valid
);

    // read beat stays up with the same word until taken
    r_hold: assert property (@(posedge clk) disable iff (rst)
        (r_valid && !r_ready) |=> (r_valid && $stable(r_data)))
        else $error("r_valid dropped or r_data moved before r_ready");

    // no new read address while a response is out
    ar_blocked: assert property (@(posedge clk) disable iff (rst)
        r_valid |-> !ar_ready)
        else $error("ar_ready high while r_valid is high");

    b_hold: assert property (@(posedge clk) disable iff (rst)
        (b_valid && !b_ready) |=> b_valid)
        else $error("b_valid dropped before b_ready");

    // strobe is a single cycle
    uart_pulse: assert property (@(posedge clk) disable iff (rst)
        uart_valid |=> !uart_valid)
        else $error("uart_valid high for two cycles in a row");

endmodule

bind sim_bus_top sim_bus_assertions sim_bus_assertions_inst (
    .clk        (clk),
    .rst        (rst),
    .ar_ready   (ar_ready),
    .r_valid    (r_valid),
    .r_data     (r_data),
    .r_ready    (r_ready),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .uart_valid (uart_valid)
);

`default_nettype wire

//--- verification/sim_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sim_bus_tb;
    import sim_bus_pkg::*;

    localparam int clk_period     = 8;
    localparam int n_rows         = 20;
    localparam int wait_limit     = 40;
    // address, delay up to 16, stall up to 4, handshakes, idle edges
    localparam int row_max_cycles = 32;
    localparam int run_cycles     = n_rows * row_max_cycles + 20;

    localparam logic op_read  = 1'b0;
    localparam logic op_write = 1'b1;

    // word every read must return
    localparam logic [data_w-1:0] fill_word = 32'hFFFF_FF21;

    typedef struct packed {
        logic              is_write;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [lat_w-1:0]  exp_lat;
        logic              uart_en;
        logic [7:0]        uart_byte;
    } row_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              ar_valid;
    logic [addr_w-1:0] ar_addr;
    logic              ar_ready;
    logic              r_valid;
    logic [data_w-1:0] r_data;
    logic              r_ready;
    logic              aw_valid;
    logic [addr_w-1:0] aw_addr;
    logic              aw_ready;
    logic              w_valid;
    bus_write_t        w_beat;
    logic              w_ready;
    logic              b_valid;
    logic              b_ready;
    logic              uart_valid;
    logic [7:0]        uart_byte;

    row_t              rows [n_rows];
    logic [lat_w-1:0]  rd_lat_m;
    logic [lat_w-1:0]  wr_lat_m;
    int                cycle = 0;
    int                w_hs_cycle = 0;
    int                uart_pulses = 0;
    int                uart_cycle = 0;
    logic [7:0]        uart_seen = 8'h00;

    sim_bus_top sim_bus_top_inst (
        .clk        (clk),
        .rst        (rst),
        .ar_valid   (ar_valid),
        .ar_addr    (ar_addr),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_data     (r_data),
        .r_ready    (r_ready),
        .aw_valid   (aw_valid),
        .aw_addr    (aw_addr),
        .aw_ready   (aw_ready),
        .w_valid    (w_valid),
        .w_beat     (w_beat),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .uart_valid (uart_valid),
        .uart_byte  (uart_byte)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // record every uart strobe with the edge it came on
    always @(negedge clk) begin
        if (uart_valid) begin
            uart_pulses <= uart_pulses + 1;
            uart_cycle  <= cycle;
            uart_seen   <= uart_byte;
        end
    end

    initial begin
        #(run_cycles * clk_period);
        $display("timeout: run still going after %0d cycles", run_cycles);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // error reporting

    task automatic fail_value(input string what, input logic [31:0] got,
                              input logic [31:0] want);
        $display("[FAIL] time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
        $display("tests failed");
        $fatal(1, "value check failed");
    endtask

    task automatic fail_state(input string what);
        $display("[FAIL] time %0t: %s", $time, what);
        $display("tests failed");
        $fatal(1, "state check failed");
    endtask

    ////////////////////
    // stimulus table

    function automatic row_t make_row(input logic op, input logic [addr_w-1:0] addr,
                                      input logic [data_w-1:0] data, input logic [lat_w-1:0] lat,
                                      input logic uart_en, input logic [7:0] ubyte);
        return {op, addr, data, lat, uart_en, ubyte};
    endfunction

    // op, address, write data, delay of that channel, uart strobe and byte
    task automatic load_rows();
        rows[0]  = make_row(op_read,  32'h0000_0000, 32'h0000_0000, 4'd5,  1'b0, 8'h00);
        rows[1]  = make_row(op_write, 32'h0000_0100, 32'h0000_0012, 4'd5,  1'b0, 8'h00);
        rows[2]  = make_row(op_write, 32'h0000_1000, 32'hDEAD_BE41, 4'd5,  1'b1, 8'h41);
        rows[3]  = make_row(op_write, 32'h0000_1004, 32'h0000_0037, 4'd5,  1'b0, 8'h00);
        rows[4]  = make_row(op_read,  32'h0000_0040, 32'h0000_0000, 4'd7,  1'b0, 8'h00);
        rows[5]  = make_row(op_write, 32'h0000_2000, 32'h0000_0099, 4'd3,  1'b0, 8'h00);
        rows[6]  = make_row(op_write, 32'h0000_1004, 32'hFFFF_FF00, 4'd3,  1'b0, 8'h00);
        rows[7]  = make_row(op_read,  32'h0000_1004, 32'h0000_0000, 4'd0,  1'b0, 8'h00);
        rows[8]  = make_row(op_write, 32'h0000_1000, 32'h0000_00A5, 4'd0,  1'b1, 8'hA5);
        rows[9]  = make_row(op_write, 32'h0000_1004, 32'h0000_00FF, 4'd0,  1'b0, 8'h00);
        rows[10] = make_row(op_read,  32'h0000_0008, 32'h0000_0000, 4'd15, 1'b0, 8'h00);
        // upper address bits are ignored, this one hits the latency register
        rows[11] = make_row(op_write, 32'h8000_5004, 32'h0000_0092, 4'd15, 1'b0, 8'h00);
        rows[12] = make_row(op_write, 32'h0000_1008, 32'h0000_0055, 4'd9,  1'b0, 8'h00);
        rows[13] = make_row(op_read,  32'h0000_1000, 32'h0000_0000, 4'd2,  1'b0, 8'h00);
        rows[14] = make_row(op_write, 32'h0000_1000, 32'h0000_003C, 4'd9,  1'b1, 8'h3C);
        rows[15] = make_row(op_write, 32'h0000_0FFC, 32'h0000_0011, 4'd9,  1'b0, 8'h00);
        rows[16] = make_row(op_read,  32'h0000_0FFC, 32'h0000_0000, 4'd2,  1'b0, 8'h00);
        rows[17] = make_row(op_write, 32'h0000_1004, 32'h0000_005A, 4'd9,  1'b0, 8'h00);
        rows[18] = make_row(op_read,  32'h0000_0010, 32'h0000_0000, 4'd10, 1'b0, 8'h00);
        rows[19] = make_row(op_write, 32'h0000_1000, 32'h0000_0007, 4'd5,  1'b1, 8'h07);
    endtask

    ////////////////////
    // bus master

    task automatic do_read(input row_t row, input logic [lat_w-1:0] lat);
        int edges;
        int stall;
        ar_valid = 1'b1;
        ar_addr  = row.addr;
        assert (ar_ready) else fail_state("ar_ready low with the read channel idle");
        @(posedge clk);
        @(negedge clk);
        ar_valid = 1'b0;
        edges = 0;
        while (!r_valid && edges < wait_limit) begin
            assert (!ar_ready) else fail_state("ar_ready high while a read is pending");
            @(posedge clk);
            @(negedge clk);
            edges++;
        end
        assert (edges == int'(lat) + 1)
            else fail_value("read delay in edges", edges, int'(lat) + 1);
        assert (r_data == fill_word) else fail_value("r_data", r_data, fill_word);
        stall = int'($urandom % 5);
        repeat (stall) begin
            @(posedge clk);
            @(negedge clk);
            assert (r_valid && !ar_ready) else fail_state("read response not held while stalled");
            assert (r_data == fill_word) else fail_value("r_data", r_data, fill_word);
        end
        r_ready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        r_ready = 1'b0;
        assert (!r_valid && ar_ready) else fail_state("read channel not idle after r handshake");
    endtask

    task automatic do_write(input row_t row, input logic [lat_w-1:0] lat);
        int edges;
        int stall;
        aw_valid    = 1'b1;
        aw_addr     = row.addr;
        w_beat.data = row.data;
        w_beat.strb = 4'hF;
        assert (aw_ready) else fail_state("aw_ready low with the write channel idle");
        @(posedge clk);
        @(negedge clk);
        aw_valid = 1'b0;
        w_valid  = 1'b1;
        edges = 0;
        while (!w_ready && edges < wait_limit) begin
            assert (!aw_ready && !b_valid) else fail_state("write channel moved before w_ready");
            @(posedge clk);
            @(negedge clk);
            edges++;
        end
        assert (edges == int'(lat) + 1)
            else fail_value("write delay in edges", edges, int'(lat) + 1);
        // w handshake edge
        @(posedge clk);
        @(negedge clk);
        w_hs_cycle = cycle;
        w_valid = 1'b0;
        assert (!w_ready && b_valid && !aw_ready) else fail_state("no write response after w beat");
        stall = int'($urandom % 5);
        repeat (stall) begin
            @(posedge clk);
            @(negedge clk);
            assert (b_valid && !aw_ready) else fail_state("write response not held while stalled");
        end
        b_ready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        b_ready = 1'b0;
        assert (!b_valid && aw_ready) else fail_state("write channel not idle after b handshake");
    endtask

    ////////////////////
    // main sequence

    initial begin
        int   pulses_before;
        logic uart_expected;
        logic cfg_write;
        void'($urandom(6));
        rst      = 1'b1;
        ar_valid = 1'b0;
        ar_addr  = '0;
        r_ready  = 1'b0;
        aw_valid = 1'b0;
        aw_addr  = '0;
        w_valid  = 1'b0;
        w_beat   = '0;
        b_ready  = 1'b0;
        rd_lat_m = 4'd5;
        wr_lat_m = 4'd5;
        load_rows();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (ar_ready && aw_ready && !r_valid && !w_ready && !b_valid && !uart_valid)
            else fail_state("outputs not at their reset values");

        for (int i = 0; i < n_rows; i++) begin
            pulses_before = uart_pulses;
            if (rows[i].is_write) begin
                assert (rows[i].exp_lat == wr_lat_m) else fail_state("table write delay off model");
                do_write(rows[i], wr_lat_m);
            end else begin
                assert (rows[i].exp_lat == rd_lat_m) else fail_state("table read delay off model");
                do_read(rows[i], rd_lat_m);
            end
            // idle edges so a late strobe is seen
            repeat (2) @(negedge clk);

            uart_expected = rows[i].is_write && (rows[i].addr[offset_w-1:0] == uart_offset);
            cfg_write     = rows[i].is_write && (rows[i].addr[offset_w-1:0] == latency_offset);
            assert (uart_expected == rows[i].uart_en) else fail_state("table uart column off model");
            if (uart_expected) begin
                assert (uart_pulses == pulses_before + 1)
                    else fail_value("uart strobe count", uart_pulses - pulses_before, 1);
                // event on the handshake edge, strobe on the edge after
                assert (uart_cycle == w_hs_cycle + 1)
                    else fail_value("edges from w handshake to strobe", uart_cycle - w_hs_cycle, 1);
                assert (uart_seen == rows[i].uart_byte)
                    else fail_value("uart_byte", 32'(uart_seen), 32'(rows[i].uart_byte));
            end else begin
                assert (uart_pulses == pulses_before)
                    else fail_value("unexpected uart strobes", uart_pulses - pulses_before, 0);
            end
            if (cfg_write) begin
                wr_lat_m = rows[i].data[7:4];
                rd_lat_m = rows[i].data[3:0];
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
